// ==== logic/sampler_pkg.sv ====
// Sampler shared definitions
package sampler_pkg;

  localparam int ENTROPY_W     = 64;
  localparam int COEFF_W       = 12;
  localparam int MLKEM_Q       = 3329;
  localparam int COEFF_PER_CLK = 4;
  localparam int NUM_BEATS     = 64;
  localparam int ADDR_W        = 8;

  // gearbox output rates per mode
  localparam int REJ_RATE      = 48;
  localparam int CBD_RATE      = 16;
  localparam int PISO_BUF_W    = 112;

  typedef enum logic [1:0] {
    SAMPLER_NONE = 2'd0,
    SAMPLER_REJ  = 2'd1,
    SAMPLER_CBD  = 2'd2
  } sampler_mode_e;

  typedef struct packed {
    sampler_mode_e     mode;
    logic [ADDR_W-1:0] dest_base;
  } sampler_cfg_t;

  // lane 0 in the low bits
  typedef logic [COEFF_PER_CLK-1:0][COEFF_W-1:0] coeff_vec_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    coeff_vec_t        data;
  } mem_wr_t;

  // eta = 2 pair with a in the low field
  typedef struct packed {
    logic [1:0] b;
    logic [1:0] a;
  } cbd_pair_t;

  typedef struct packed {
    logic [REJ_RATE-CBD_RATE-1:0]       rsvd;
    cbd_pair_t [COEFF_PER_CLK-1:0]      pair;
  } cbd_view_t;

  // one gearbox word read as rejection candidates or as cbd pairs
  typedef union packed {
    coeff_vec_t rej;
    cbd_view_t  cbd;
  } piso_word_u;

  typedef struct packed {
    logic piso;
    logic rej;
    logic cbd;
  } zeroize_t;

endpackage

// ==== logic/sampler_ctrl.sv ====
// Sampler control FSM
module sampler_ctrl (
  input  logic                          clk,
  input  logic                          rst_b,
  input  logic                          zeroize_i,
  input  logic                          start_i,
  input  sampler_pkg::sampler_cfg_t     cfg_i,
  input  logic                          beat_acc_i,
  output sampler_pkg::sampler_mode_e    mode_o,
  output logic [sampler_pkg::ADDR_W-1:0] addr_o,
  output logic                          busy_o,
  output logic                          done_o,
  output sampler_pkg::zeroize_t         zero_o
);
  import sampler_pkg::*;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_RUN,
    CTRL_DONE
  } ctrl_state_e;

  ctrl_state_e                  state_q, state_d;
  sampler_cfg_t                 cfg_q;
  logic [$clog2(NUM_BEATS)-1:0] beat_cnt_q;
  logic [ADDR_W-1:0]            addr_q;
  logic                         start_acc;
  logic                         last_beat;

  assign start_acc = start_i & (state_q == CTRL_IDLE);
  assign last_beat = beat_acc_i & (beat_cnt_q == NUM_BEATS - 1);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      CTRL_IDLE: if (start_i) state_d = CTRL_RUN;
      CTRL_RUN:  if (last_beat) state_d = CTRL_DONE;
      CTRL_DONE: state_d = CTRL_IDLE;
      default:   state_d = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q    <= CTRL_IDLE;
      cfg_q      <= '0;
      beat_cnt_q <= '0;
      addr_q     <= '0;
    end else if (zeroize_i) begin
      state_q    <= CTRL_IDLE;
      cfg_q      <= '0;
      beat_cnt_q <= '0;
      addr_q     <= '0;
    end else begin
      state_q <= state_d;
      if (start_acc) begin
        cfg_q      <= cfg_i;
        beat_cnt_q <= '0;
        addr_q     <= cfg_i.dest_base;
      end else if (beat_acc_i) begin
        // address wraps at 256
        beat_cnt_q <= beat_cnt_q + 1'b1;
        addr_q     <= addr_q + 1'b1;
      end
    end
  end

  // samplers only see a mode while running
  assign mode_o = (state_q == CTRL_RUN) ? cfg_q.mode : SAMPLER_NONE;
  assign addr_o = addr_q;
  assign busy_o = start_i | (state_q != CTRL_IDLE);
  assign done_o = (state_q == CTRL_DONE);

  // done flushes the gearbox and the active sampler
  assign zero_o.piso = zeroize_i | done_o;
  assign zero_o.rej  = zeroize_i | (done_o & (cfg_q.mode == SAMPLER_REJ));
  assign zero_o.cbd  = zeroize_i | (done_o & (cfg_q.mode == SAMPLER_CBD));

endmodule

// ==== logic/sampler_piso.sv ====
// Multi-rate entropy gearbox
module sampler_piso (
  input  logic                              clk,
  input  logic                              rst_b,
  input  logic                              clear_i,
  input  sampler_pkg::sampler_mode_e        mode_i,
  input  logic                              valid_i,
  input  logic [sampler_pkg::ENTROPY_W-1:0] data_i,
  output logic                              hold_o,
  output logic                              valid_o,
  output sampler_pkg::piso_word_u           word_o,
  input  logic                              hold_i
);
  import sampler_pkg::*;

  typedef logic [$clog2(PISO_BUF_W+1)-1:0] fill_t;

  logic [PISO_BUF_W-1:0] buf_q, buf_d;
  logic [PISO_BUF_W-1:0] buf_shift;
  logic [PISO_BUF_W-1:0] keep_mask;
  fill_t                 fill_q, fill_d;
  fill_t                 fill_shift;
  fill_t                 rate;
  fill_t                 shift_w;
  logic                  valid_q;
  logic                  in_acc;
  logic                  out_acc;

  assign rate = (mode_i == SAMPLER_CBD) ? fill_t'(CBD_RATE) : fill_t'(REJ_RATE);

  // room for one more word needed
  assign hold_o  = (fill_q > fill_t'(PISO_BUF_W - ENTROPY_W));
  assign in_acc  = valid_i & ~hold_o;
  assign out_acc = valid_q & ~hold_i;

  always_comb begin
    shift_w    = out_acc ? rate : '0;
    buf_shift  = buf_q >> shift_w;
    fill_shift = fill_q - shift_w;
    keep_mask  = ~({PISO_BUF_W{1'b1}} << fill_shift);
    buf_d      = buf_shift;
    fill_d     = fill_shift;
    if (in_acc) begin
      // new word lands just above the remaining bits
      buf_d  = (buf_shift & keep_mask) | (PISO_BUF_W'(data_i) << fill_shift);
      fill_d = fill_shift + fill_t'(ENTROPY_W);
    end
  end

  always_ff @(posedge clk) begin
    buf_q <= buf_d;
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      fill_q  <= '0;
      valid_q <= 1'b0;
    end else if (clear_i) begin
      fill_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      fill_q  <= fill_d;
      valid_q <= (fill_d >= rate);
    end
  end

  assign valid_o = valid_q;

  always_comb begin
    word_o = buf_q[REJ_RATE-1:0];
    // cbd uses only the low field
    if (mode_i == SAMPLER_CBD) begin
      word_o.cbd.rsvd = '0;
    end
  end

endmodule

// ==== logic/rej_sampler.sv ====
// Uniform rejection sampler
module rej_sampler (
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    clear_i,
  input  logic                    valid_i,
  input  sampler_pkg::piso_word_u word_i,
  output logic                    hold_o,
  output logic                    valid_o,
  output sampler_pkg::coeff_vec_t data_o,
  input  logic                    hold_i
);
  import sampler_pkg::*;

  logic [6:0][COEFF_W-1:0]   buf_q, buf_d;
  logic [2:0]                cnt_q, cnt_d;
  logic [COEFF_PER_CLK-1:0]  cand_ok;
  coeff_vec_t                data_q;
  logic                      valid_q;
  logic                      pop;
  logic                      in_acc;

  always_comb begin
    for (int i = 0; i < COEFF_PER_CLK; i++) begin
      cand_ok[i] = (word_i.rej[i] < MLKEM_Q);
    end
  end

  // move four out whenever the output slot frees up
  assign pop    = (cnt_q >= 3'd4) & (~valid_q | ~hold_i);
  assign hold_o = (cnt_q >= 3'd4) & valid_q & hold_i;
  assign in_acc = valid_i & ~hold_o;

  always_comb begin
    logic [2:0] wr_idx;
    buf_d  = buf_q;
    wr_idx = cnt_q;
    if (pop) begin
      for (int i = 0; i < 3; i++) begin
        buf_d[i] = buf_q[i+4];
      end
      wr_idx = cnt_q - 3'd4;
    end
    // append accepted candidates in stream order
    if (in_acc) begin
      for (int i = 0; i < COEFF_PER_CLK; i++) begin
        if (cand_ok[i]) begin
          buf_d[wr_idx] = word_i.rej[i];
          wr_idx        = wr_idx + 3'd1;
        end
      end
    end
    cnt_d = wr_idx;
  end

  always_ff @(posedge clk) begin
    buf_q <= buf_d;
    if (pop) begin
      data_q <= buf_q[3:0];
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else if (clear_i) begin
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      cnt_q   <= cnt_d;
      valid_q <= pop | (valid_q & hold_i);
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== logic/cbd_sampler.sv ====
// Centered binomial sampler
module cbd_sampler (
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    clear_i,
  input  logic                    valid_i,
  input  sampler_pkg::piso_word_u word_i,
  output logic                    hold_o,
  output logic                    valid_o,
  output sampler_pkg::coeff_vec_t data_o,
  input  logic                    hold_i
);
  import sampler_pkg::*;

  coeff_vec_t coeff;
  coeff_vec_t data_q;
  logic       valid_q;
  logic       in_acc;

  always_comb begin
    logic [1:0] pc_a;
    logic [1:0] pc_b;
    for (int i = 0; i < COEFF_PER_CLK; i++) begin
      pc_a = word_i.cbd.pair[i].a[0] + word_i.cbd.pair[i].a[1];
      pc_b = word_i.cbd.pair[i].b[0] + word_i.cbd.pair[i].b[1];
      // negative results wrap to q - |x|
      if (pc_a >= pc_b) begin
        coeff[i] = COEFF_W'(pc_a - pc_b);
      end else begin
        coeff[i] = COEFF_W'(MLKEM_Q) - COEFF_W'(pc_b - pc_a);
      end
    end
  end

  assign hold_o = valid_q & hold_i;
  assign in_acc = valid_i & ~hold_o;

  always_ff @(posedge clk) begin
    if (in_acc) begin
      data_q <= coeff;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      valid_q <= 1'b0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_acc | (valid_q & hold_i);
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== logic/sampler_top.sv ====
// Polynomial coefficient sampler
module sampler_top (
  input  logic                              clk,
  input  logic                              rst_b,
  input  logic                              zeroize_i,
  input  logic                              start_i,
  input  sampler_pkg::sampler_cfg_t         cfg_i,
  input  logic                              entropy_valid_i,
  input  logic [sampler_pkg::ENTROPY_W-1:0] entropy_data_i,
  output logic                              entropy_hold_o,
  output logic                              mem_wr_valid_o,
  output sampler_pkg::mem_wr_t              mem_wr_o,
  input  logic                              mem_wr_hold_i,
  output logic                              busy_o,
  output logic                              done_o
);
  import sampler_pkg::*;

  sampler_mode_e     mode;
  logic [ADDR_W-1:0] addr;
  zeroize_t          zero;
  logic              beat_acc;
  logic              run;

  logic              piso_in_valid, piso_in_hold;
  logic              piso_valid, piso_hold;
  piso_word_u        piso_word;

  logic              rej_in_valid, rej_in_hold, rej_out_hold;
  logic              rej_valid;
  coeff_vec_t        rej_data;
  logic              cbd_in_valid, cbd_in_hold, cbd_out_hold;
  logic              cbd_valid;
  coeff_vec_t        cbd_data;

  sampler_ctrl u_ctrl (
    .clk        (clk),
    .rst_b      (rst_b),
    .zeroize_i  (zeroize_i),
    .start_i    (start_i),
    .cfg_i      (cfg_i),
    .beat_acc_i (beat_acc),
    .mode_o     (mode),
    .addr_o     (addr),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .zero_o     (zero)
  );

  // entropy only flows while a sampler is running
  assign run            = busy_o & (mode != SAMPLER_NONE);
  assign entropy_hold_o = ~run | piso_in_hold;
  assign piso_in_valid  = entropy_valid_i & run;

  sampler_piso u_piso (
    .clk     (clk),
    .rst_b   (rst_b),
    .clear_i (zero.piso),
    .mode_i  (mode),
    .valid_i (piso_in_valid),
    .data_i  (entropy_data_i),
    .hold_o  (piso_in_hold),
    .valid_o (piso_valid),
    .word_o  (piso_word),
    .hold_i  (piso_hold)
  );

  assign rej_in_valid = piso_valid & (mode == SAMPLER_REJ);
  assign cbd_in_valid = piso_valid & (mode == SAMPLER_CBD);
  assign piso_hold    = ((mode == SAMPLER_REJ) & rej_in_hold) |
                        ((mode == SAMPLER_CBD) & cbd_in_hold) |
                        (mode == SAMPLER_NONE);

  // unselected sampler is stalled
  assign rej_out_hold = mem_wr_hold_i | (mode != SAMPLER_REJ);
  assign cbd_out_hold = mem_wr_hold_i | (mode != SAMPLER_CBD);

  rej_sampler u_rej (
    .clk     (clk),
    .rst_b   (rst_b),
    .clear_i (zero.rej),
    .valid_i (rej_in_valid),
    .word_i  (piso_word),
    .hold_o  (rej_in_hold),
    .valid_o (rej_valid),
    .data_o  (rej_data),
    .hold_i  (rej_out_hold)
  );

  cbd_sampler u_cbd (
    .clk     (clk),
    .rst_b   (rst_b),
    .clear_i (zero.cbd),
    .valid_i (cbd_in_valid),
    .word_i  (piso_word),
    .hold_o  (cbd_in_hold),
    .valid_o (cbd_valid),
    .data_o  (cbd_data),
    .hold_i  (cbd_out_hold)
  );

  always_comb begin
    mem_wr_valid_o = 1'b0;
    mem_wr_o.addr  = addr;
    mem_wr_o.data  = '0;
    unique case (mode)
      SAMPLER_REJ: begin
        mem_wr_valid_o = rej_valid;
        mem_wr_o.data  = rej_data;
      end
      SAMPLER_CBD: begin
        mem_wr_valid_o = cbd_valid;
        mem_wr_o.data  = cbd_data;
      end
      default: begin
        mem_wr_valid_o = 1'b0;
      end
    endcase
  end

  assign beat_acc = mem_wr_valid_o & ~mem_wr_hold_i;

endmodule

// ==== verification/sampler_tb.sv ====
// Sampler testbench
module sampler_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import sampler_pkg::*;

  localparam int CLK_PERIOD    = 10;
  localparam int NUM_RUNS      = 6;
  // generous margin for rejections, 50% entropy gaps and 50% hold
  localparam int CYC_PER_BEAT  = 52;
  localparam int WATCHDOG_NS   = NUM_RUNS * NUM_BEATS * CYC_PER_BEAT * CLK_PERIOD;
  localparam int RUN_LIMIT     = 5000;

  logic                 clk = 1'b0;
  logic                 rst_b;
  logic                 zeroize_i;
  logic                 start_i;
  sampler_cfg_t         cfg_i;
  logic                 entropy_valid_i;
  logic [ENTROPY_W-1:0] entropy_data_i;
  logic                 entropy_hold_o;
  logic                 mem_wr_valid_o;
  mem_wr_t              mem_wr_o;
  logic                 mem_wr_hold_i;
  logic                 busy_o;
  logic                 done_o;

  integer               seed = 32'he4bc;
  logic [31:0]          rnd;
  bit                   stall_en = 1'b0;
  sampler_mode_e        cur_mode = SAMPLER_NONE;
  logic [ADDR_W-1:0]    cur_base = '0;
  int                   wr_cnt = 0;
  int                   cyc = 0;
  int                   last_wr_cyc = -1;
  int                   fail_cnt = 0;
  int                   test_cnt = 0;
  bit                   stream_q[$];
  logic [COEFF_W-1:0]   exp_q[$];

  sampler_top DUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cyc++;
  end

  // random words every cycle with gaps and hold only when stalling
  always @(posedge clk) begin
    #1;
    entropy_data_i = {$random(seed), $random(seed)};
    if (stall_en) begin
      rnd             = $random(seed);
      entropy_valid_i = rnd[0];
      mem_wr_hold_i   = rnd[1];
    end else begin
      entropy_valid_i = 1'b1;
      mem_wr_hold_i   = 1'b0;
    end
  end

  task automatic flag_error(input string msg);
    fail_cnt++;
    $display("[FAIL] %0t %s", $time, msg);
  endtask

  // pull fields off the logged stream until need coefficients are queued
  task automatic fill_expected(input int need);
    logic [COEFF_W-1:0] field;
    int                 na;
    int                 nb;
    while (exp_q.size() < need) begin
      if (cur_mode == SAMPLER_REJ && stream_q.size() >= COEFF_W) begin
        for (int i = 0; i < COEFF_W; i++) begin
          field[i] = stream_q.pop_front();
        end
        if (field < MLKEM_Q) exp_q.push_back(field);
      end else if (cur_mode == SAMPLER_CBD && stream_q.size() >= 4) begin
        na = stream_q.pop_front();
        na += stream_q.pop_front();
        nb = stream_q.pop_front();
        nb += stream_q.pop_front();
        exp_q.push_back(COEFF_W'((na - nb + MLKEM_Q) % MLKEM_Q));
      end else begin
        return;
      end
    end
  endtask

  task automatic check_write();
    mem_wr_t            wr;
    logic [ADDR_W-1:0]  exp_addr;
    logic [COEFF_W-1:0] exp_c;
    wr       = mem_wr_o;
    exp_addr = cur_base + ADDR_W'(wr_cnt);
    fill_expected(COEFF_PER_CLK);
    assert (wr.addr == exp_addr)
      else flag_error($sformatf("write %0d addr %h, expected %h", wr_cnt, wr.addr, exp_addr));
    for (int j = 0; j < COEFF_PER_CLK; j++) begin
      if (exp_q.size() == 0) begin
        fail_cnt++;
        $display("write %0d came before enough entropy was accepted", wr_cnt);
        break;
      end
      exp_c = exp_q.pop_front();
      assert (wr.data[j] == exp_c)
        else flag_error($sformatf("write %0d lane %0d is %0d, expected %0d",
                                  wr_cnt, j, wr.data[j], exp_c));
      if (cur_mode == SAMPLER_REJ) begin
        assert (wr.data[j] < MLKEM_Q)
          else flag_error($sformatf("rej coefficient %0d not below q", wr.data[j]));
      end else begin
        assert (wr.data[j] <= 2 || wr.data[j] >= MLKEM_Q - 2)
          else flag_error($sformatf("cbd coefficient %0d out of range", wr.data[j]));
      end
    end
    wr_cnt++;
    last_wr_cyc = cyc;
  endtask

  // sample mid-cycle where inputs and outputs have settled
  always @(negedge clk) begin
    if (rst_b && !zeroize_i) begin
      assert (busy_o || entropy_hold_o)
        else flag_error("entropy_hold_o low while idle");
      if (entropy_valid_i && !entropy_hold_o) begin
        for (int i = 0; i < ENTROPY_W; i++) begin
          stream_q.push_back(entropy_data_i[i]);
        end
      end
      if (mem_wr_valid_o && !mem_wr_hold_i) check_write();
      if (done_o) begin
        assert (wr_cnt == NUM_BEATS && last_wr_cyc == cyc - 1)
          else flag_error($sformatf("done after %0d writes, last write %0d cycles back",
                                    wr_cnt, cyc - last_wr_cyc));
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_b)
    (mem_wr_valid_o && mem_wr_hold_i && !zeroize_i) |=> (mem_wr_valid_o && $stable(mem_wr_o)))
    else flag_error("mem_wr_o changed while held");

  assert property (@(posedge clk) disable iff (!rst_b) done_o |=> (!done_o && !busy_o))
    else flag_error("done_o longer than one cycle or busy_o still high after it");

  assert property (@(posedge clk) disable iff (!rst_b)
    (busy_o && !done_o && !zeroize_i) |=> busy_o)
    else flag_error("busy_o dropped before done_o");

  assert property (@(posedge clk) disable iff (!rst_b) !busy_o |-> !mem_wr_valid_o)
    else flag_error("mem_wr_valid_o high while idle");

  task automatic run_sampler(input string name, input sampler_mode_e mode,
                             input logic [ADDR_W-1:0] base, input bit stall, input int zero_at);
    int n;
    int err0;
    err0 = fail_cnt;
    n    = 0;
    stream_q.delete();
    exp_q.delete();
    wr_cnt   = 0;
    cur_mode = mode;
    cur_base = base;
    stall_en = stall;
    @(posedge clk);
    #1;
    start_i         = 1'b1;
    cfg_i.mode      = mode;
    cfg_i.dest_base = base;
    @(negedge clk);
    assert (busy_o) else flag_error("busy_o low in the start cycle");
    @(posedge clk);
    #1;
    start_i = 1'b0;
    if (zero_at > 0) begin
      while (wr_cnt < zero_at && n < RUN_LIMIT) begin
        @(posedge clk);
        n++;
      end
      if (wr_cnt < zero_at) begin
        fail_cnt++;
        $display("%s never reached write %0d before zeroize", name, zero_at);
      end
      #1;
      zeroize_i = 1'b1;
      @(posedge clk);
      #1;
      zeroize_i = 1'b0;
      repeat (4) begin
        @(negedge clk);
        assert (!busy_o && !mem_wr_valid_o && entropy_hold_o)
          else flag_error("sampler still active after zeroize");
      end
    end else begin
      while (!done_o && n < RUN_LIMIT) begin
        @(negedge clk);
        n++;
      end
      if (!done_o) begin
        fail_cnt++;
        $display("%s never reached done_o", name);
      end else begin
        assert (wr_cnt == NUM_BEATS)
          else flag_error($sformatf("%0d writes instead of %0d", wr_cnt, NUM_BEATS));
        @(negedge clk);
        assert (!busy_o) else flag_error("busy_o high in the cycle after done_o");
      end
    end
    stall_en = 1'b0;
    test_cnt++;
    $display("%s: %0d writes, %0d errors", name, wr_cnt, fail_cnt - err0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("sim failed");
    $finish;
  end

  initial begin
    rst_b           = 1'b0;
    zeroize_i       = 1'b0;
    start_i         = 1'b0;
    cfg_i           = '0;
    entropy_valid_i = 1'b0;
    entropy_data_i  = '0;
    mem_wr_hold_i   = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_b = 1'b1;
    @(negedge clk);
    assert (!busy_o && !done_o && !mem_wr_valid_o && entropy_hold_o)
      else flag_error("outputs wrong after reset");
    run_sampler("rej basic", SAMPLER_REJ, 8'h00, 1'b0, 0);
    run_sampler("cbd basic", SAMPLER_CBD, 8'hd0, 1'b0, 0);
    run_sampler("rej backpressure", SAMPLER_REJ, 8'hf0, 1'b1, 0);
    run_sampler("cbd backpressure", SAMPLER_CBD, 8'h40, 1'b1, 0);
    run_sampler("zeroize mid-run", SAMPLER_REJ, 8'h20, 1'b1, 20);
    run_sampler("after zeroize", SAMPLER_REJ, 8'h80, 1'b1, 0);
    repeat (3) @(posedge clk);
    $display("%0d tests run, %0d checks failed", test_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
logic/sampler_pkg.sv
logic/sampler_ctrl.sv
logic/sampler_piso.sv
logic/rej_sampler.sv
logic/cbd_sampler.sv
logic/sampler_top.sv
verification/sampler_tb.sv

// ==== Bender.yml ====
package:
  name: sampler

sources:
  - files:
      - logic/sampler_pkg.sv
      - logic/sampler_ctrl.sv
      - logic/sampler_piso.sv
      - logic/rej_sampler.sv
      - logic/cbd_sampler.sv
      - logic/sampler_top.sv
  - target: test
    files:
      - verification/sampler_tb.sv
